//--- run.sh
#!/bin/sh
# Build and run the JP sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module jp_tb \
    -Mdir obj_dir -o jp_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/jp_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

//--- sim.f
+incdir+src
src/jp_pkg.sv
src/jp_cond_decoder.sv
src/jp_prog_ram.sv
src/jp_sequencer.sv
src/jp_axil_regs.sv
src/jp_top.sv
sim/jp_checker.sv
sim/jp_asserts.sv
sim/jp_tb.sv

//--- sim/jp_asserts.sv
/* JP sequencer assertions: reset state, legal FSM states, start lock, halt reason */
`timescale 1ns/1ns
`default_nettype none

module jp_asserts
    import jp_pkg::*;
(
    input logic         clk,
    input logic         rst_n,
    input logic         start,
    input logic         busy,
    input seq_state_e   state,
    input halt_reason_e halt_reason
);

    int fail_count = 0;

    a_idle_after_reset: assert property (@(posedge clk) !rst_n |=> !busy)
        else begin
            $error("busy high after reset");
            fail_count++;
        end

    a_legal_state: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {ST_IDLE, ST_OPC, ST_LO, ST_HI, ST_EXEC})
        else begin
            $error("illegal sequencer state");
            fail_count++;
        end

    // Register block drops a start while busy, so none reaches the FSM
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !busy)
        else begin
            $error("start reached the sequencer while busy");
            fail_count++;
        end

    a_halt_reason: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> halt_reason != HR_NONE)
        else begin
            $error("run ended without a halt reason");
            fail_count++;
        end

endmodule

bind jp_sequencer jp_asserts i_jp_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .busy        (busy),
    .state       (state),
    .halt_reason (halt_reason)
);

`default_nettype wire

//--- sim/jp_checker.sv
/* JP checker: mirrors AXI writes, runs the reference model when a run ends
   and compares PC, status and step count */
`timescale 1ns/1ns
`default_nettype none
`include "jp_defines.svh"

module jp_checker
    import jp_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [11:0] awaddr,
    input  logic        awvalid,
    input  logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    input  logic        wready,
    input  logic [1:0]  bresp,
    input  logic        bvalid,
    input  logic        bready,
    input  logic [11:0] araddr,
    input  logic        arvalid,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  logic        rvalid,
    input  logic        rready,
    input  logic [7:0]  pc,
    input  logic        busy,
    output int          error_count
);

    logic [7:0]  prog_m [256];
    logic [7:0]  flags_m;
    logic [15:0] limit_m;
    logic [11:0] wr_addr_q;
    logic [31:0] wr_data_q;
    logic [11:0] rd_addr_q;
    logic        rd_busy_q;
    logic        busy_prev = 1'b0;
    logic        exp_valid = 1'b0;
    logic [7:0]  exp_pc;
    logic [1:0]  exp_reason;
    logic [15:0] exp_steps;

    initial error_count = 0;

    // Steps the mirrored program under the Z80 JP subset rules
    function automatic void jp_ref_run(output logic [7:0] fpc, output logic [1:0] reason,
                                       output logic [15:0] steps);
        logic [7:0] p;
        logic [7:0] op;
        logic       take;
        logic       done;
        int         n;
        p = 8'd0;
        steps = 16'd0;
        reason = HR_NONE;
        done = 1'b0;
        for (n = 0; n < 70000 && !done; n++) begin
            op = prog_m[p];
            steps = steps + 16'd1;
            if (op == 8'h76) begin
                p = p + 8'd1;
                reason = HR_HALT;
                done = 1'b1;
            end else if (op == 8'h00) begin
                p = p + 8'd1;
            end else if (op == 8'hC3) begin
                p = prog_m[p + 8'd1];
            end else if (op[7:6] == 2'b11 && op[2:0] == 3'b010) begin
                case (op[5:3])
                    3'd0:    take = !flags_m[6];  // NZ
                    3'd1:    take = flags_m[6];
                    3'd2:    take = !flags_m[0];  // NC
                    3'd3:    take = flags_m[0];
                    3'd4:    take = !flags_m[2];  // PO
                    3'd5:    take = flags_m[2];
                    3'd6:    take = !flags_m[7];  // P
                    default: take = flags_m[7];
                endcase
                p = take ? prog_m[p + 8'd1] : p + 8'd3;
            end else begin
                p = p + 8'd1;
                reason = HR_ILLEGAL;
                done = 1'b1;
            end
            if (!done && steps >= limit_m) begin
                reason = HR_LIMIT;
                done = 1'b1;
            end
        end
        fpc = p;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            flags_m <= 8'h00;
            limit_m <= `JP_LIMIT_RST;
        end else begin
            if ((awvalid && awready) != (wvalid && wready)) begin
                $display("Write address and write data were accepted in different cycles");
                error_count++;
            end
            if (awvalid && awready && wvalid && wready) begin
                wr_addr_q <= awaddr;
                wr_data_q <= wdata;
            end
            if (bvalid && bready && bresp == 2'b00) begin
                if (wr_addr_q == `JP_REG_FLAGS) begin
                    flags_m <= wr_data_q[7:0];
                end else if (wr_addr_q == `JP_REG_LIMIT) begin
                    limit_m <= wr_data_q[15:0];
                end else if (wr_addr_q >= `JP_PROG_BASE) begin
                    prog_m[8'((wr_addr_q - `JP_PROG_BASE) >> 2)] <= wr_data_q[7:0];
                end
            end
            if (arvalid && arready) begin
                rd_addr_q <= araddr;
                rd_busy_q <= busy;
            end
            if (rvalid && rready && exp_valid && !rd_busy_q) begin
                case (rd_addr_q)
                    `JP_REG_STATUS: compare("status", rdata, {29'd0, exp_reason, 1'b0});
                    `JP_REG_PC:     compare("pc register", rdata, {24'd0, exp_pc});
                    `JP_REG_STEPS:  compare("step_count", rdata, {16'd0, exp_steps});
                    default: ;
                endcase
            end
        end
    end

    // End of a run seen at the falling edge where pc is stable
    always @(negedge clk) begin
        busy_prev <= busy;
        if (busy_prev && !busy) begin
            jp_ref_run(exp_pc, exp_reason, exp_steps);
            exp_valid = 1'b1;
            compare("pc", {24'd0, pc}, {24'd0, exp_pc});
        end
    end

endmodule

`default_nettype wire

//--- sim/jp_tb.sv
/* JP sequencer testbench: AXI4-Lite stimulus for jumps, conditions, limits,
   register rules and random programs */
`timescale 1ns/1ns
`default_nettype none
`include "jp_defines.svh"

module jp_tb
    import jp_pkg::*;
();

    localparam int WAIT_MAX = 20000;

    logic        clk;
    logic        rst_n;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [11:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [7:0]  pc;
    logic        busy;
    int          tb_errors;
    int          chk_errors;
    int          assert_errors;
    logic [31:0] rng;
    logic [7:0]  cur_flags;

    jp_top i_jp_top (
        .clk, .rst_n,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .pc, .busy
    );

    jp_checker i_jp_checker (
        .clk, .rst_n,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rvalid, .rready,
        .pc, .busy,
        .error_count (chk_errors)
    );

    assign assert_errors = i_jp_top.i_jp_sequencer.i_jp_asserts.fail_count;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic fail_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
            tb_errors++;
        end
    endtask

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) fail_timeout("a write response");
        end while (!bvalid);
        resp    = bresp;
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) fail_timeout("a read response");
        end while (!rvalid);
        data    = rdata;
        resp    = rresp;
        arvalid = 1'b0;
    endtask

    task automatic write_ok(input logic [11:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        check_val("bresp", resp, 2'b00);
    endtask

    task automatic put_byte(input logic [7:0] a, input logic [7:0] v);
        write_ok(`JP_PROG_BASE + {2'b00, a, 2'b00}, v);
    endtask

    task automatic set_flags(input logic [7:0] f);
        cur_flags = f;
        write_ok(`JP_REG_FLAGS, f);
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while (busy !== level) begin
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) fail_timeout(level ? "busy to rise" : "busy to fall");
        end
    endtask

    // Start, wait for the end, read back status, PC and steps for the checker
    task automatic run_prog(output logic [31:0] status, output logic [31:0] steps);
        logic [31:0] d;
        logic [1:0]  resp;
        write_ok(`JP_REG_CTRL, 32'h1);
        wait_busy(1'b1);
        wait_busy(1'b0);
        axi_read(`JP_REG_STATUS, status, resp);
        axi_read(`JP_REG_PC, d, resp);
        axi_read(`JP_REG_STEPS, steps, resp);
    endtask

    initial begin
        logic [31:0] st;
        logic [31:0] steps;
        logic [31:0] d;
        logic [31:0] s1;
        logic [31:0] r;
        logic [1:0]  resp;
        logic [7:0]  p;
        logic [7:0]  t;
        int          a;
        int          k;
        int          c;
        logic [7:0]  legal [11];

        legal = '{8'h00, 8'hC3, 8'hC2, 8'hCA, 8'hD2, 8'hDA,
                  8'hE2, 8'hEA, 8'hF2, 8'hFA, 8'h76};
        tb_errors = 0;
        rng = 32'd46;
        cur_flags = 8'h00;
        rst_n = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b1;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (a = 0; a < 256; a++) begin
            put_byte(8'(a), 8'(a) ^ 8'hA5);  // Fill over the whole address
        end

        // NOPs ending in HALT
        for (a = 0; a < 6; a++) put_byte(8'(a), 8'h00);
        put_byte(8'd6, 8'h76);
        run_prog(st, steps);
        check_val("halt_reason", st[2:1], HR_HALT);
        check_val("step_count", steps, 32'd7);
        check_val("pc", pc, 8'd7);

        // Every condition under every flag combination
        put_byte(8'd1, 8'h10);
        put_byte(8'd2, 8'h00);
        put_byte(8'd3, 8'h76);
        put_byte(8'h10, 8'h76);
        for (c = 0; c < 8; c++) begin
            put_byte(8'd0, {2'b11, 3'(c), 3'b010});
            for (k = 0; k < 16; k++) begin
                set_flags({k[3], k[0], 3'b000, k[2], 1'b0, k[1]});  // S Z PV C
                run_prog(st, steps);
            end
        end

        // JP nn chains, high operand byte is ignored
        for (c = 0; c < 3; c++) begin
            p = 8'd0;
            for (k = 1; k <= 5; k++) begin
                r = next_rand();
                t = 8'(16 * k) + 8'(r % 12);
                put_byte(p, 8'hC3);
                put_byte(p + 8'd1, t);
                put_byte(p + 8'd2, r[15:8] | 8'h01);
                p = t;
            end
            put_byte(p, 8'h76);
            run_prog(st, steps);
            check_val("step_count", steps, 32'd6);
        end

        // Illegal opcode, then a JP-to-self loop under a limit of 20
        put_byte(8'd0, 8'h00);
        put_byte(8'd1, 8'hED);
        run_prog(st, steps);
        check_val("halt_reason", st[2:1], HR_ILLEGAL);
        put_byte(8'd0, 8'hC3);
        put_byte(8'd1, 8'h00);
        put_byte(8'd2, 8'h00);
        write_ok(`JP_REG_LIMIT, 32'd20);
        run_prog(st, steps);
        check_val("halt_reason", st[2:1], HR_LIMIT);
        check_val("step_count", steps, 32'd20);

        // Register rules while busy
        write_ok(`JP_REG_LIMIT, 32'd200);
        write_ok(`JP_REG_CTRL, 32'h1);
        wait_busy(1'b1);
        axi_write(`JP_REG_FLAGS, 32'hFF, resp);
        check_val("bresp flags busy", resp, 2'b10);
        axi_write(`JP_PROG_BASE, 32'h76, resp);
        check_val("bresp program busy", resp, 2'b10);
        axi_write(`JP_REG_LIMIT, 32'd5, resp);
        check_val("bresp limit busy", resp, 2'b10);
        axi_write(12'h018, 32'h1, resp);
        check_val("bresp unmapped", resp, 2'b10);
        axi_read(12'h030, d, resp);
        check_val("rresp unmapped", resp, 2'b10);
        axi_read(`JP_PROG_BASE, d, resp);
        check_val("rresp program", resp, 2'b00);
        check_val("rdata program", d, 32'h0);
        axi_read(`JP_REG_STEPS, s1, resp);
        write_ok(`JP_REG_CTRL, 32'h1);
        axi_read(`JP_REG_STEPS, d, resp);
        if (d < s1) begin
            $display("Step count restarted after a start while busy");
            tb_errors++;
        end
        wait_busy(1'b0);
        axi_read(`JP_REG_FLAGS, d, resp);
        check_val("flags", d, {24'd0, cur_flags});
        run_prog(st, steps);
        check_val("step_count", steps, 32'd200);

        // Random programs over the legal opcodes with a HALT pad
        write_ok(`JP_REG_LIMIT, `JP_LIMIT_RST);
        for (c = 0; c < 4; c++) begin
            r = next_rand();
            set_flags(r[7:0]);
            a = 0;
            while (a < 48) begin
                r = next_rand();
                put_byte(8'(a), legal[r % 11]);
                a++;
                if (legal[r % 11] != 8'h00 && legal[r % 11] != 8'h76) begin
                    put_byte(8'(a), 8'(r[23:16] % 56));
                    put_byte(8'(a + 1), r[31:24]);
                    a += 2;
                end
            end
            for (; a < 256; a++) put_byte(8'(a), 8'h76);
            run_prog(st, steps);
        end

        @(negedge clk);
        $display("Errors: testbench %0d, checker %0d, assertions %0d",
                 tb_errors, chk_errors, assert_errors);
        if (tb_errors == 0 && chk_errors == 0 && assert_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/jp_axil_regs.sv
/* JP register block: AXI4-Lite slave for control, flags, step limit, status
   and program loading, with a write lock while the sequencer runs */
`timescale 1ns/1ns
`default_nettype none
`include "jp_defines.svh"

module jp_axil_regs
    import jp_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`JP_ADDR_W-1:0]   awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`JP_DATA_W-1:0]   wdata,
    input  logic [`JP_DATA_W/8-1:0] wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [`JP_ADDR_W-1:0]   araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [`JP_DATA_W-1:0]   rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    output logic                    start,
    output logic [7:0]              flags,
    output logic [15:0]             step_limit,
    output logic                    prog_we,
    output logic [`JP_PROG_AW-1:0]  prog_waddr,
    output logic [7:0]              prog_wdata,
    input  logic                    busy,
    input  halt_reason_e            halt_reason,
    input  logic [`JP_PROG_AW-1:0]  pc,
    input  logic [15:0]             step_count
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic                  wr_fire;
    logic                  rd_fire;
    logic [`JP_ADDR_W-1:0] aw_off;
    logic [`JP_ADDR_W-1:0] ar_off;
    logic                  aw_prog;
    logic                  ar_prog;
    logic                  wr_err;
    logic                  rd_err;
    logic [`JP_DATA_W-1:0] rd_word;

    // AW and W are taken together, one write in flight
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;

    assign arready = !rvalid;
    assign rd_fire = arvalid && arready;

    assign aw_off  = awaddr - `JP_PROG_BASE;
    assign ar_off  = araddr - `JP_PROG_BASE;
    assign aw_prog = (awaddr >= `JP_PROG_BASE) &&
                     (aw_off[`JP_ADDR_W-1:2] < (1 << `JP_PROG_AW));
    assign ar_prog = (araddr >= `JP_PROG_BASE) &&
                     (ar_off[`JP_ADDR_W-1:2] < (1 << `JP_PROG_AW));

    always_comb begin
        case (awaddr)
            `JP_REG_CTRL:  wr_err = 1'b0;  // Start while busy is dropped, not refused
            `JP_REG_FLAGS,
            `JP_REG_LIMIT: wr_err = busy;
            default:       wr_err = aw_prog ? busy : 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bvalid     <= 1'b0;
            bresp      <= RESP_OKAY;
            start      <= 1'b0;
            prog_we    <= 1'b0;
            flags      <= '0;
            step_limit <= `JP_LIMIT_RST;
        end else begin
            start   <= 1'b0;
            prog_we <= 1'b0;
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= wr_err ? RESP_SLVERR : RESP_OKAY;
                if (!wr_err && wstrb[0]) begin
                    case (awaddr)
                        `JP_REG_CTRL:  start <= wdata[0] && !busy;
                        `JP_REG_FLAGS: flags <= wdata[7:0];
                        `JP_REG_LIMIT: step_limit[7:0] <= wdata[7:0];
                        default:       prog_we <= 1'b1;  // Only program space is left
                    endcase
                end
                if (!wr_err && wstrb[1] && awaddr == `JP_REG_LIMIT) begin
                    step_limit[15:8] <= wdata[15:8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            prog_waddr <= aw_off[`JP_PROG_AW+1:2];
            prog_wdata <= wdata[7:0];
        end
    end

    always_comb begin
        rd_err = 1'b0;
        case (araddr)
            `JP_REG_CTRL:   rd_word = '0;  // Write only
            `JP_REG_FLAGS:  rd_word = `JP_DATA_W'(flags);
            `JP_REG_LIMIT:  rd_word = `JP_DATA_W'(step_limit);
            `JP_REG_STATUS: rd_word = `JP_DATA_W'({halt_reason, busy});
            `JP_REG_PC:     rd_word = `JP_DATA_W'(pc);
            `JP_REG_STEPS:  rd_word = `JP_DATA_W'(step_count);
            default: begin
                rd_word = '0;  // Program space reads back as zero
                rd_err  = !ar_prog;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else begin
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end
        end
    end

    // Status is sampled at the AR handshake
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

//--- src/jp_cond_decoder.sv
/* JP condition decoder: classifies the opcode and evaluates the JP cc,nn condition
   against the Z, C, PV and S flags */
`timescale 1ns/1ns
`default_nettype none

module jp_cond_decoder
    import jp_pkg::*;
(
    input  logic [7:0] opcode,
    input  logic [7:0] flags,
    output op_class_e  op_class,
    output logic       cond_taken
);

    cond_e cc;
    logic  flag_z;
    logic  flag_c;
    logic  flag_pv;
    logic  flag_s;
    logic  sel_zc;
    logic  sel_pvs;
    logic  sel_flag;

    assign cc = cond_e'(opcode[5:3]);

    // F register layout
    assign flag_s  = flags[7];
    assign flag_z  = flags[6];
    assign flag_pv = flags[2];
    assign flag_c  = flags[0];

    always_comb begin
        casez (opcode)
            8'h00:       op_class = OP_NOP;
            8'hC3:       op_class = OP_JP;
            8'h76:       op_class = OP_HALT;
            8'b11???010: op_class = OP_JPCC;  // JP cc,nn
            default:     op_class = OP_ILLEGAL;
        endcase
    end

    // cc[2:1] picks the flag: 00 Z, 01 C, 10 PV, 11 S
    assign sel_zc   = cc[1] ? flag_c : flag_z;
    assign sel_pvs  = cc[1] ? flag_s : flag_pv;
    assign sel_flag = cc[2] ? sel_pvs : sel_zc;

    // cc[0] is the wanted flag value
    assign cond_taken = (op_class == OP_JPCC) && (sel_flag ~^ cc[0]);

endmodule

`default_nettype wire

//--- src/jp_defines.svh
/* JP sequencer widths, AXI4-Lite register map and reset values */
`ifndef JP_DEFINES_SVH
`define JP_DEFINES_SVH

// Program memory and PC
`define JP_PROG_AW      8

// AXI4-Lite bus
`define JP_DATA_W       32
`define JP_ADDR_W       12

// Register map
`define JP_REG_CTRL     12'h000
`define JP_REG_FLAGS    12'h004
`define JP_REG_LIMIT    12'h008
`define JP_REG_STATUS   12'h00C
`define JP_REG_PC       12'h010
`define JP_REG_STEPS    12'h014
`define JP_PROG_BASE    12'h100  // One byte per word from here

// Step limit after reset
`define JP_LIMIT_RST    16'd1000

`endif

//--- src/jp_pkg.sv
/* JP sequencer types: opcode classes, jump conditions, FSM states, halt reasons */
`default_nettype none

package jp_pkg;

    typedef enum logic [2:0] {
        OP_NOP,
        OP_JP,
        OP_JPCC,
        OP_HALT,
        OP_ILLEGAL
    } op_class_e;

    // Same encoding as opcode bits 5:3
    typedef enum logic [2:0] {
        CC_NZ,
        CC_Z,
        CC_NC,
        CC_C,
        CC_PO,
        CC_PE,
        CC_P,
        CC_M
    } cond_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_OPC,
        ST_LO,
        ST_HI,
        ST_EXEC
    } seq_state_e;

    typedef enum logic [1:0] {
        HR_NONE,
        HR_HALT,
        HR_ILLEGAL,
        HR_LIMIT
    } halt_reason_e;

endpackage

`default_nettype wire

//--- src/jp_prog_ram.sv
/* Program memory: byte wide, one write port, registered read port */
`timescale 1ns/1ns
`default_nettype none
`include "jp_defines.svh"

module jp_prog_ram #(
    parameter int DEPTH_AW = `JP_PROG_AW
) (
    input  logic                clk,
    input  logic                we,
    input  logic [DEPTH_AW-1:0] waddr,
    input  logic [7:0]          wdata,
    input  logic [DEPTH_AW-1:0] rd_addr,
    output logic [7:0]          rd_data
);

    logic [7:0] mem [1 << DEPTH_AW];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rd_data <= mem[rd_addr];  // One cycle latency
    end

endmodule

`default_nettype wire

//--- src/jp_sequencer.sv
/* JP sequencer: fetch and execute FSM with PC, operand latch, step counter
   and halt reasons */
`timescale 1ns/1ns
`default_nettype none
`include "jp_defines.svh"

module jp_sequencer
    import jp_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic [15:0]            step_limit,
    output logic [`JP_PROG_AW-1:0] rd_addr,
    input  logic [7:0]             rd_data,
    output logic [7:0]             opcode,
    input  op_class_e              op_class,
    input  logic                   cond_taken,
    output logic                   busy,
    output halt_reason_e           halt_reason,
    output logic [`JP_PROG_AW-1:0] pc,
    output logic [15:0]            step_count
);

    seq_state_e             state;
    logic [7:0]             opcode_q;
    logic [`JP_PROG_AW-1:0] lo_q;
    logic [`JP_PROG_AW-1:0] next_pc;
    logic [15:0]            step_next;

    assign busy      = (state != ST_IDLE);
    assign step_next = step_count + 16'd1;

    // Opcode byte is already on rd_data in ST_OPC
    assign opcode = (state == ST_OPC) ? rd_data : opcode_q;

    always_comb begin
        case (op_class)
            OP_JP:   next_pc = lo_q;
            OP_JPCC: next_pc = cond_taken ? lo_q : pc + `JP_PROG_AW'(3);
            default: next_pc = pc + `JP_PROG_AW'(1);
        endcase
    end

    // Address runs one byte ahead of the state that consumes it
    always_comb begin
        case (state)
            ST_OPC:  rd_addr = pc + `JP_PROG_AW'(1);
            ST_LO:   rd_addr = pc + `JP_PROG_AW'(2);
            ST_EXEC: rd_addr = next_pc;
            default: rd_addr = '0;  // Prefetch of byte 0 while idle
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            pc          <= '0;
            step_count  <= '0;
            halt_reason <= HR_NONE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state       <= ST_OPC;
                        pc          <= '0;
                        step_count  <= '0;
                        halt_reason <= HR_NONE;
                    end
                end
                ST_OPC: begin
                    if (op_class == OP_JP || op_class == OP_JPCC) begin
                        state <= ST_LO;
                    end else begin
                        state <= ST_EXEC;
                    end
                end
                ST_LO:   state <= ST_HI;
                ST_HI:   state <= ST_EXEC;  // High operand byte is dropped
                ST_EXEC: begin
                    // HALT and illegal opcodes count as a step too
                    pc         <= next_pc;
                    step_count <= step_next;
                    if (op_class == OP_HALT) begin
                        state       <= ST_IDLE;
                        halt_reason <= HR_HALT;
                    end else if (op_class == OP_ILLEGAL) begin
                        state       <= ST_IDLE;
                        halt_reason <= HR_ILLEGAL;
                    end else if (step_next >= step_limit) begin
                        state       <= ST_IDLE;
                        halt_reason <= HR_LIMIT;
                    end else begin
                        state <= ST_OPC;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_OPC) begin
            opcode_q <= rd_data;
        end
        if (state == ST_LO) begin
            lo_q <= rd_data[`JP_PROG_AW-1:0];  // Low byte of nn
        end
    end

endmodule

`default_nettype wire

//--- src/jp_top.sv
/* JP subsystem top: AXI4-Lite register block, sequencer, condition decoder
   and program memory */
`timescale 1ns/1ns
`default_nettype none
`include "jp_defines.svh"

module jp_top
    import jp_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`JP_ADDR_W-1:0]   awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`JP_DATA_W-1:0]   wdata,
    input  logic [`JP_DATA_W/8-1:0] wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [`JP_ADDR_W-1:0]   araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [`JP_DATA_W-1:0]   rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [`JP_PROG_AW-1:0]  pc,
    output logic                    busy
);

    logic                   start;
    logic [7:0]             flags;
    logic [15:0]            step_limit;
    logic                   prog_we;
    logic [`JP_PROG_AW-1:0] prog_waddr;
    logic [7:0]             prog_wdata;
    logic [`JP_PROG_AW-1:0] rd_addr;
    logic [7:0]             rd_data;
    logic [7:0]             opcode;
    op_class_e              op_class;
    logic                   cond_taken;
    halt_reason_e           halt_reason;
    logic [15:0]            step_count;

    jp_axil_regs i_jp_axil_regs (
        .clk, .rst_n,
        .awaddr, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .start, .flags, .step_limit,
        .prog_we, .prog_waddr, .prog_wdata,
        .busy, .halt_reason, .pc, .step_count
    );

    jp_sequencer i_jp_sequencer (
        .clk, .rst_n, .start, .step_limit,
        .rd_addr, .rd_data,
        .opcode, .op_class, .cond_taken,
        .busy, .halt_reason, .pc, .step_count
    );

    jp_cond_decoder i_jp_cond_decoder (
        .opcode, .flags, .op_class, .cond_taken
    );

    jp_prog_ram #(
        .DEPTH_AW (`JP_PROG_AW)
    ) i_jp_prog_ram (
        .clk,
        .we      (prog_we),
        .waddr   (prog_waddr),
        .wdata   (prog_wdata),
        .rd_addr,
        .rd_data
    );

endmodule

`default_nettype wire
